// ==== bridge_defs.svh ====
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// bus widths shared by core and memory sides
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32
`define BRIDGE_BEN_W  4              // one enable per byte lane

// instruction memory window
`define IMEM_BASE     32'h0000_0000
`define IMEM_SIZE     32'h0000_4000  // 16 KiB

// data memory window
`define DMEM_BASE     32'h8000_0000
`define DMEM_SIZE     32'h0000_4000  // 16 KiB

`endif

// ==== bridge_pkg.sv ====
`default_nettype none
`include "bridge_defs.svh"

package bridge_pkg;

	// request as the core issues it, stb is a one-cycle pulse
	typedef struct packed {
		logic [`BRIDGE_ADDR_W-1:0] addr;
		logic [`BRIDGE_DATA_W-1:0] data;
		logic [`BRIDGE_BEN_W-1:0]  ben;
		logic                      rw;   // 1 = write
		logic                      stb;
	} core_req_t;

	// response toward the core, ack and err are pulses
	typedef struct packed {
		logic [`BRIDGE_DATA_W-1:0] data;
		logic                      ack;
		logic                      err;  // comes together with ack
	} core_rsp_t;

	// wishbone classic request toward a memory port
	typedef struct packed {
		logic                      cyc;
		logic                      stb;
		logic                      we;
		logic [`BRIDGE_BEN_W-1:0]  wstrb;
		logic [`BRIDGE_ADDR_W-1:0] addr;
		logic [`BRIDGE_DATA_W-1:0] data;
	} wb_req_t;

	// memory answer, data valid while ack is high
	typedef struct packed {
		logic [`BRIDGE_DATA_W-1:0] data;
		logic                      ack;
	} wb_rsp_t;

endpackage

`default_nettype wire

// ==== core_req_capture.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defs.svh"

module core_req_capture (
	input  wire logic                  clk_core,
	input  wire logic                  rst_core,
	input  wire bridge_pkg::core_req_t req_i,   // strobe from the core
	input  wire logic                  done_i,  // current request finished
	output bridge_pkg::core_req_t      held_o,  // request held for the bus
	output logic                       busy_o
);

	import bridge_pkg::*;

	core_req_t hold_q;  // payload of the accepted request
	logic      busy_q;  // one request in flight
	logic      take;    // accept a new request

	// a strobe that arrives while busy is dropped
	assign take = req_i.stb & ~busy_q;

	// control state
	always_ff @(posedge clk_core) begin
		if (rst_core) begin
			busy_q <= 1'b0;
		end else if (take) begin
			busy_q <= 1'b1;
		end else if (done_i) begin
			busy_q <= 1'b0;  // ack or err seen downstream
		end
	end

	// payload only loads on accept
	always_ff @(posedge clk_core) begin
		if (take) begin
			hold_q <= req_i;
		end
	end

	// stb of the held request tracks busy, not the stored pulse
	always_comb begin
		held_o     = hold_q;
		held_o.stb = busy_q;
	end

	assign busy_o = busy_q;

endmodule

`default_nettype wire

// ==== addr_window_check.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defs.svh"

module addr_window_check #(
	parameter logic [`BRIDGE_ADDR_W-1:0] WIN_BASE = `IMEM_BASE,
	parameter logic [`BRIDGE_ADDR_W-1:0] WIN_SIZE = `IMEM_SIZE
) (
	input  wire logic                  clk_core,
	input  wire logic                  rst_core,
	input  wire bridge_pkg::core_req_t held_i,
	output bridge_pkg::wb_req_t        wb_req_o,
	input  wire bridge_pkg::wb_rsp_t   wb_rsp_i,
	output bridge_pkg::core_rsp_t      rsp_o,     // raw, not yet synchronized
	output logic                       done_o
);

	import bridge_pkg::*;

	logic [`BRIDGE_ADDR_W-1:0] offset;   // address relative to the window
	logic                      in_win;
	logic                      fin_q;    // response given last cycle
	logic                      active;
	logic                      bus_go;   // wishbone cycle open
	logic                      err_go;   // out-of-window reject
	logic                      mem_ack;
	core_rsp_t                 rsp;

	// unsigned wrap makes addresses below the base fail too
	assign offset = held_i.addr - WIN_BASE;
	assign in_win = offset < WIN_SIZE;

	// held request still waiting for its answer
	assign active  = held_i.stb & ~fin_q;
	assign bus_go  = active & in_win;
	assign err_go  = active & ~in_win;
	assign mem_ack = bus_go & wb_rsp_i.ack;

	always_comb begin
		wb_req_o.cyc   = bus_go;
		wb_req_o.stb   = bus_go;
		wb_req_o.we    = held_i.rw;
		wb_req_o.wstrb = held_i.ben;
		wb_req_o.addr  = held_i.addr;
		wb_req_o.data  = held_i.data;
	end

	always_comb begin
		rsp.data = mem_ack ? wb_rsp_i.data : '0;
		rsp.ack  = mem_ack | err_go;  // a reject is acked as well
		rsp.err  = err_go;
	end

	// keeps the answer to a single pulse per held request
	always_ff @(posedge clk_core) begin
		if (rst_core) begin
			fin_q <= 1'b0;
		end else begin
			fin_q <= done_o;
		end
	end

	assign rsp_o  = rsp;
	assign done_o = rsp.ack;

endmodule

`default_nettype wire

// ==== rsp_sync.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defs.svh"

module rsp_sync (
	input  wire logic                  clk_core,
	input  wire logic                  rst_core,
	input  wire bridge_pkg::core_rsp_t rsp_i,  // straight from the memory path
	output bridge_pkg::core_rsp_t      rsp_o   // one cycle later
);

	import bridge_pkg::*;

	core_rsp_t rsp_q;

	// breaks the path from memory ack back into the core
	always_ff @(posedge clk_core) begin
		if (rst_core) begin
			rsp_q <= '0;
		end else begin
			rsp_q <= rsp_i;
		end
	end

	assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// ==== core_bus_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defs.svh"

module core_bus_bridge (
	input  wire logic                  clk_core,
	input  wire logic                  rst_core,

	// instruction port of the core
	input  wire bridge_pkg::core_req_t ibus_req_i,
	output bridge_pkg::core_rsp_t      ibus_rsp_o,

	// data port of the core
	input  wire bridge_pkg::core_req_t dbus_req_i,
	output bridge_pkg::core_rsp_t      dbus_rsp_o,

	// wishbone memory ports
	output bridge_pkg::wb_req_t        imem_req_o,
	input  wire bridge_pkg::wb_rsp_t   imem_rsp_i,
	output bridge_pkg::wb_req_t        dmem_req_o,
	input  wire bridge_pkg::wb_rsp_t   dmem_rsp_i
);

	import bridge_pkg::*;

	core_req_t ibus_held;  // instruction chain
	logic      ibus_done;
	core_rsp_t ibus_raw;

	core_req_t dbus_held;  // data chain
	logic      dbus_done;
	core_rsp_t dbus_raw;

	// instruction port
	core_req_capture i_ibus_capture (
		.clk_core (clk_core),
		.rst_core (rst_core),
		.req_i    (ibus_req_i),
		.done_i   (ibus_done),
		.held_o   (ibus_held),
		.busy_o   ()            // held stb carries the same level
	);

	addr_window_check #(
		.WIN_BASE (`IMEM_BASE),
		.WIN_SIZE (`IMEM_SIZE)
	) i_ibus_check (
		.clk_core (clk_core),
		.rst_core (rst_core),
		.held_i   (ibus_held),
		.wb_req_o (imem_req_o),
		.wb_rsp_i (imem_rsp_i),
		.rsp_o    (ibus_raw),
		.done_o   (ibus_done)
	);

	rsp_sync i_ibus_sync (
		.clk_core (clk_core),
		.rst_core (rst_core),
		.rsp_i    (ibus_raw),
		.rsp_o    (ibus_rsp_o)
	);

	// data port, independent of the instruction port
	core_req_capture i_dbus_capture (
		.clk_core (clk_core),
		.rst_core (rst_core),
		.req_i    (dbus_req_i),
		.done_i   (dbus_done),
		.held_o   (dbus_held),
		.busy_o   ()
	);

	addr_window_check #(
		.WIN_BASE (`DMEM_BASE),
		.WIN_SIZE (`DMEM_SIZE)
	) i_dbus_check (
		.clk_core (clk_core),
		.rst_core (rst_core),
		.held_i   (dbus_held),
		.wb_req_o (dmem_req_o),
		.wb_rsp_i (dmem_rsp_i),
		.rsp_o    (dbus_raw),
		.done_o   (dbus_done)
	);

	rsp_sync i_dbus_sync (
		.clk_core (clk_core),
		.rst_core (rst_core),
		.rsp_i    (dbus_raw),
		.rsp_o    (dbus_rsp_o)
	);

endmodule

`default_nettype wire

// ==== tb_core_bus_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defs.svh"

module tb_core_bus_bridge;

	import bridge_pkg::*;

	localparam int N_TXN     = 300;  // per port
	localparam int RESET_CYC = 10;

	typedef struct packed {
		core_req_t   req;
		core_rsp_t   rsp;
		logic        oow;     // outside the window
		logic [31:0] edge_n;  // edge that samples the strobe
	} exp_t;

	logic        clk_core;
	logic        rst_core;
	core_req_t   ibus_req;
	core_req_t   dbus_req;
	core_rsp_t   ibus_rsp;
	core_rsp_t   dbus_rsp;
	wb_req_t     imem_req;
	wb_req_t     dmem_req;
	wb_rsp_t     imem_rsp;
	wb_rsp_t     dmem_rsp;

	logic [31:0] lfsr_q = 32'h21dc1c3a;
	logic [31:0] mem [2][4096];     // memory models
	logic [31:0] shadow [2][4096];  // what the memories should hold
	exp_t        exp_q [2][$];      // requests waiting for their answer
	int          mem_wait [2];
	logic        mem_busy [2];
	logic [31:0] mem_ack_edge [2];
	int          resp_cnt [2];
	logic [31:0] edge_cnt;
	int          err_cnt;
	int          check_cnt;

	core_bus_bridge i_core_bus_bridge (
		.clk_core   (clk_core),
		.rst_core   (rst_core),
		.ibus_req_i (ibus_req),
		.ibus_rsp_o (ibus_rsp),
		.dbus_req_i (dbus_req),
		.dbus_rsp_o (dbus_rsp),
		.imem_req_o (imem_req),
		.imem_rsp_i (imem_rsp),
		.dmem_req_o (dmem_req),
		.dmem_rsp_i (dmem_rsp)
	);

	initial begin
		clk_core = 1'b0;
		forever #5 clk_core = ~clk_core;
	end

	always @(posedge clk_core) edge_cnt <= edge_cnt + 1;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_take(input int nbits);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			v      = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [31:0] win_base(input int p);
		return (p == 0) ? `IMEM_BASE : `DMEM_BASE;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] wdata,
			input logic [3:0] ben);
		logic [31:0] w;
		w = old_w;
		for (int b = 0; b < 4; b++) begin
			if (ben[b]) w[8*b +: 8] = wdata[8*b +: 8];
		end
		return w;
	endfunction

	// expected answer from the shadow memory and the window rule
	function automatic core_rsp_t expected_rsp(input int p, input core_req_t r);
		core_rsp_t   e;
		logic [31:0] size;
		size   = (p == 0) ? `IMEM_SIZE : `DMEM_SIZE;
		e.ack  = 1'b1;
		e.err  = !(r.addr >= win_base(p) && r.addr < win_base(p) + size);
		e.data = (e.err || r.rw) ? '0 : shadow[p][r.addr[13:2]];  // writes answer zero
		return e;
	endfunction

	function automatic core_req_t random_req(input int p);
		core_req_t   r;
		logic [31:0] idx;
		idx    = lfsr_take(1) ? lfsr_take(4) : lfsr_take(12);  // mostly a small hot region
		r.addr = win_base(p) + {idx[11:0], 2'b00};
		if (lfsr_take(3) == 0) r.addr = r.addr + 32'h4000;  // just past the window
		r.data = lfsr_take(32);
		r.ben  = lfsr_take(4);
		r.rw   = lfsr_take(1);
		r.stb  = 1'b1;
		return r;
	endfunction

	task automatic check_value(input int p, input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		check_cnt++;
		assert (act_v === exp_v) else begin
			err_cnt++;
			$display("FAIL %s %s: expected %h, got %h", (p == 0) ? "ibus" : "dbus", name,
				exp_v, act_v);
		end
	endtask

	task automatic check_idle();
		check_value(0, "ack,err,cyc,stb,busy", 0, {ibus_rsp.ack, ibus_rsp.err, imem_req.cyc,
			imem_req.stb, i_core_bus_bridge.i_ibus_capture.busy_o});
		check_value(1, "ack,err,cyc,stb,busy", 0, {dbus_rsp.ack, dbus_rsp.err, dmem_req.cyc,
			dmem_req.stb, i_core_bus_bridge.i_dbus_capture.busy_o});
	endtask

	task automatic drive_req(input int p, input core_req_t r);
		if (p == 0) ibus_req = r;
		else dbus_req = r;
	endtask

	task automatic run_port(input int p);
		core_req_t r;
		exp_t      e;
		int        seen;
		for (int n = 0; n < N_TXN; n++) begin
			@(posedge clk_core);
			#1;
			r        = random_req(p);
			e.req    = r;
			e.rsp    = expected_rsp(p, r);
			e.oow    = e.rsp.err;
			e.edge_n = edge_cnt + 1;
			if (r.rw && !e.oow) begin
				shadow[p][r.addr[13:2]] = merge_bytes(shadow[p][r.addr[13:2]], r.data, r.ben);
			end
			exp_q[p].push_back(e);
			seen = resp_cnt[p];
			drive_req(p, r);
			@(posedge clk_core);
			#1;
			r     = random_req(p);
			r.stb = lfsr_take(2) == 0;  // lands while busy, must be dropped
			drive_req(p, r);
			@(posedge clk_core);
			#1;
			drive_req(p, '0);
			while (resp_cnt[p] == seen) @(posedge clk_core);
		end
	endtask

	// answers after 0 to 3 wait cycles, ack lasts one cycle
	task automatic serve_memory(input int p, input wb_req_t q);
		wb_rsp_t     a;
		logic [11:0] idx;
		a   = (p == 0) ? imem_rsp : dmem_rsp;
		idx = q.addr[13:2];
		if (a.ack) begin
			a = '0;
		end else if (q.cyc && q.stb) begin
			if (!mem_busy[p]) begin
				mem_busy[p] = 1'b1;
				mem_wait[p] = lfsr_take(2);
			end
			if (mem_wait[p] == 0) begin
				mem_busy[p] = 1'b0;
				a.ack       = 1'b1;
				a.data      = q.we ? '0 : mem[p][idx];
				if (q.we) mem[p][idx] = merge_bytes(mem[p][idx], q.data, q.wstrb);
			end else begin
				mem_wait[p]--;
			end
		end
		if (p == 0) imem_rsp = a;
		else dmem_rsp = a;
	endtask

	always @(posedge clk_core) begin
		#1;
		serve_memory(0, imem_req);
		serve_memory(1, dmem_req);
	end

	task automatic watch_port(input int p, input core_rsp_t rsp, input wb_req_t q,
			input wb_rsp_t a);
		exp_t e;
		if (q.cyc) begin
			assert (exp_q[p].size() != 0 && !exp_q[p][0].oow) else begin
				err_cnt++;
				$display("port %0d opened a bus cycle with no in-window request pending", p);
			end
			if (exp_q[p].size() != 0) begin
				e = exp_q[p][0];
				check_value(p, "wb.stb", 1, q.stb);
				check_value(p, "wb.we", e.req.rw, q.we);
				check_value(p, "wb.wstrb", e.req.ben, q.wstrb);
				check_value(p, "wb.addr", e.req.addr, q.addr);
				check_value(p, "wb.data", e.req.data, q.data);
			end
			if (a.ack) mem_ack_edge[p] = edge_cnt + 1;  // core ack due after that edge
		end
		if (rsp.ack || rsp.err) begin
			assert (exp_q[p].size() != 0) else begin
				err_cnt++;
				$display("port %0d answered although no request was pending", p);
			end
			if (exp_q[p].size() != 0) begin
				e = exp_q[p].pop_front();
				check_value(p, "rsp.ack", e.rsp.ack, rsp.ack);
				check_value(p, "rsp.err", e.rsp.err, rsp.err);
				check_value(p, "rsp.data", e.rsp.data, rsp.data);
				check_value(p, "rsp edge", e.oow ? e.edge_n + 1 : mem_ack_edge[p], edge_cnt);
				resp_cnt[p]++;
			end
		end
	endtask

	always @(negedge clk_core) begin
		if (!rst_core) begin
			watch_port(0, ibus_rsp, imem_req, imem_rsp);
			watch_port(1, dbus_rsp, dmem_req, dmem_rsp);
		end
	end

	initial begin
		rst_core  = 1'b1;
		ibus_req  = '0;
		dbus_req  = '0;
		imem_rsp  = '0;
		dmem_rsp  = '0;
		edge_cnt  = '0;
		err_cnt   = 0;
		check_cnt = 0;
		for (int p = 0; p < 2; p++) begin
			mem_busy[p]     = 1'b0;
			mem_wait[p]     = 0;
			resp_cnt[p]     = 0;
			mem_ack_edge[p] = '0;
			for (int i = 0; i < 4096; i++) begin
				mem[p][i]    = (win_base(p) ^ 32'h3c5a_0000) + 32'(i) * 32'h0001_0004;
				shadow[p][i] = mem[p][i];
			end
		end
		repeat (RESET_CYC - 1) @(posedge clk_core);
		@(negedge clk_core);
		check_idle();
		@(posedge clk_core);
		#1;
		rst_core = 1'b0;
		repeat (4) begin
			@(negedge clk_core);
			check_idle();
		end
		fork
			run_port(0);
			run_port(1);
		join
		repeat (5) @(posedge clk_core);
		assert (exp_q[0].size() == 0 && exp_q[1].size() == 0) else begin
			err_cnt++;
			$display("some requests never got a response");
		end
		$display("checks: %0d  errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (RESET_CYC + 2 * N_TXN * 20) @(posedge clk_core);
		$display("watchdog expired before all requests finished, checks: %0d  errors: %0d",
			check_cnt, err_cnt);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
bridge_pkg.sv
core_req_capture.sv
addr_window_check.sv
rsp_sync.sv
core_bus_bridge.sv
tb_core_bus_bridge.sv

// ==== Bender.yml ====
package:
  name: core_bus_bridge

export_include_dirs:
  - .

sources:
  - files:
      - bridge_pkg.sv
      - core_req_capture.sv
      - addr_window_check.sv
      - rsp_sync.sv
      - core_bus_bridge.sv

  - target: test
    files:
      - tb_core_bus_bridge.sv
